//--- hw/udp_frame_pkg.sv
/*
 * Field and stream types for decoded UDP frames.
 * Headers carry only the fields the echo path reads or writes; MAC and
 * the remaining IP fields are handled outside this core.
 */

`default_nettype none

package udp_frame_pkg;

    // Header field widths
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [15:0] udp_csum_t;
    typedef logic [7:0]  ip_ttl_t;

    // One 64-bit payload beat and its byte enables
    typedef logic [63:0] pay_data_t;
    typedef logic [7:0]  pay_keep_t;

    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dst_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        udp_len_t  length;
        udp_csum_t checksum;
        ip_ttl_t   ttl;
    } udp_hdr_t;

    // Last marks end of frame, user marks a bad frame from upstream
    typedef struct packed {
        pay_data_t data;
        pay_keep_t keep;
        logic      last;
        logic      user;
    } pay_beat_t;

endpackage

`default_nettype wire

//--- hw/echo_cfg_pkg.sv
/*
 * Fixed configuration of the UDP echo responder.
 * Depends on udp_frame_pkg, which must be compiled first.
 * PAY_FIFO_AW must stay equal to log2 of PAY_FIFO_DEPTH.
 */

`default_nettype none

package echo_cfg_pkg;

    // Source address of every reply, 192.168.1.128
    localparam udp_frame_pkg::ip_addr_t LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    // Only frames to this port are answered
    localparam udp_frame_pkg::udp_port_t ECHO_PORT = 16'd1234;

    localparam udp_frame_pkg::ip_ttl_t REPLY_TTL = 8'd64;

    // Payload buffer size in beats
    localparam int PAY_FIFO_DEPTH = 16;
    localparam int PAY_FIFO_AW    = 4;

endpackage

`default_nettype wire

//--- hw/echo_ctrl.sv
/*
 * Per-frame echo or discard decision.
 * Every header must be followed by at least one payload beat, the last one
 * flagged; a new header is only taken once the previous frame has ended.
 */

`timescale 1ns/1ps
`default_nettype none

module echo_ctrl (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  udp_frame_pkg::udp_port_t dst_port,
    output logic                     hdr_load,
    input  logic                     hdr_slot_free,

    input  logic                     rx_pay_valid,
    output logic                     rx_pay_ready,
    input  logic                     pay_last,
    output logic                     fifo_wr,
    input  logic                     fifo_free
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PASSING,
        ST_DROPPING
    } state_t;

    state_t state;
    logic   port_match;
    logic   hdr_xfer;
    logic   pay_end;

    assign port_match = (dst_port == echo_cfg_pkg::ECHO_PORT);

    // Discarded headers never need the reply slot
    assign rx_hdr_ready = (state == ST_IDLE) && (!port_match || hdr_slot_free);
    assign hdr_xfer     = rx_hdr_valid && rx_hdr_ready;
    assign hdr_load     = hdr_xfer && port_match;

    // Dropped beats are acknowledged and go nowhere
    assign rx_pay_ready = ((state == ST_PASSING) && fifo_free) || (state == ST_DROPPING);
    assign fifo_wr      = (state == ST_PASSING) && rx_pay_valid && fifo_free;
    assign pay_end      = rx_pay_valid && rx_pay_ready && pay_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_xfer) begin
                        state <= port_match ? ST_PASSING : ST_DROPPING;
                    end
                end
                ST_PASSING, ST_DROPPING: begin
                    if (pay_end) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/reply_header_reg.sv
/*
 * Single-entry holding register for the outgoing reply header.
 * Loading while the slot is full and not draining overwrites it, so
 * hdr_load must only be asserted while hdr_slot_free is high.
 */

`timescale 1ns/1ps
`default_nettype none

module reply_header_reg (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    hdr_load,
    input  udp_frame_pkg::udp_hdr_t rx_hdr,
    output logic                    hdr_slot_free,

    output logic                    tx_hdr_valid,
    input  logic                    tx_hdr_ready,
    output udp_frame_pkg::udp_hdr_t tx_hdr
);

    // Free also when the held header leaves in this cycle
    assign hdr_slot_free = !tx_hdr_valid || tx_hdr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_hdr_valid <= 1'b0;
        end else if (hdr_load) begin
            tx_hdr_valid <= 1'b1;
        end else if (tx_hdr_ready) begin
            tx_hdr_valid <= 1'b0;
        end
    end

    // Reply goes back to the sender with ports swapped
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            tx_hdr.src_ip   <= echo_cfg_pkg::LOCAL_IP;
            tx_hdr.dst_ip   <= rx_hdr.src_ip;
            tx_hdr.src_port <= rx_hdr.dst_port;
            tx_hdr.dst_port <= rx_hdr.src_port;
            tx_hdr.length   <= rx_hdr.length;
            tx_hdr.checksum <= '0;
            tx_hdr.ttl      <= echo_cfg_pkg::REPLY_TTL;
        end
    end

endmodule

`default_nettype wire

//--- hw/payload_fifo.sv
/*
 * Payload beat FIFO with a registered output stage.
 * A beat written into an empty FIFO is presented on the next cycle.
 * fifo_free counts the output stage, so at most PAY_FIFO_DEPTH beats are held.
 */

`timescale 1ns/1ps
`default_nettype none

module payload_fifo (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     fifo_wr,
    input  udp_frame_pkg::pay_beat_t wr_beat,
    output logic                     fifo_free,

    output logic                     tx_pay_valid,
    input  logic                     tx_pay_ready,
    output udp_frame_pkg::pay_beat_t tx_pay
);

    localparam int AW = echo_cfg_pkg::PAY_FIFO_AW;

    udp_frame_pkg::pay_beat_t mem [echo_cfg_pkg::PAY_FIFO_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   mem_count;
    logic [AW:0]   fill;
    logic          out_take;
    logic          mem_rd;
    logic          mem_wr;
    logic          bypass;

    assign fill      = mem_count + {{AW{1'b0}}, tx_pay_valid};
    assign fifo_free = fill < (AW + 1)'(echo_cfg_pkg::PAY_FIFO_DEPTH);

    // Output stage is empty or drains in this cycle
    assign out_take = !tx_pay_valid || tx_pay_ready;
    assign mem_rd   = out_take && (mem_count != '0);
    // Skip the memory when nothing older is waiting in it
    assign bypass   = out_take && (mem_count == '0) && fifo_wr;
    assign mem_wr   = fifo_wr && !bypass;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            mem_count    <= '0;
            tx_pay_valid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            mem_count <= mem_count + {{AW{1'b0}}, mem_wr} - {{AW{1'b0}}, mem_rd};
            if (out_take) begin
                tx_pay_valid <= mem_rd || bypass;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[wr_ptr] <= wr_beat;
        end
        if (mem_rd) begin
            tx_pay <= mem[rd_ptr];
        end else if (bypass) begin
            tx_pay <= wr_beat;
        end
    end

endmodule

`default_nettype wire

//--- hw/udp_echo_core.sv
/*
 * UDP echo responder on decoded header and payload streams.
 * Frames to the echo port are answered to their sender; all others are
 * consumed and dropped. Reply headers may run ahead of buffered payload.
 */

`timescale 1ns/1ps
`default_nettype none

module udp_echo_core (
    input  logic                     clk,
    input  logic                     rst,

    // Received frames
    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  udp_frame_pkg::udp_hdr_t  rx_hdr,
    input  logic                     rx_pay_valid,
    output logic                     rx_pay_ready,
    input  udp_frame_pkg::pay_beat_t rx_pay,

    // Reply frames
    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output udp_frame_pkg::udp_hdr_t  tx_hdr,
    output logic                     tx_pay_valid,
    input  logic                     tx_pay_ready,
    output udp_frame_pkg::pay_beat_t tx_pay
);

    logic hdr_load;
    logic hdr_slot_free;
    logic fifo_wr;
    logic fifo_free;

    echo_ctrl echo_ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .rx_hdr_valid  (rx_hdr_valid),
        .rx_hdr_ready  (rx_hdr_ready),
        .dst_port      (rx_hdr.dst_port),
        .hdr_load      (hdr_load),
        .hdr_slot_free (hdr_slot_free),
        .rx_pay_valid  (rx_pay_valid),
        .rx_pay_ready  (rx_pay_ready),
        .pay_last      (rx_pay.last),
        .fifo_wr       (fifo_wr),
        .fifo_free     (fifo_free)
    );

    reply_header_reg reply_header_reg_inst (
        .clk           (clk),
        .rst           (rst),
        .hdr_load      (hdr_load),
        .rx_hdr        (rx_hdr),
        .hdr_slot_free (hdr_slot_free),
        .tx_hdr_valid  (tx_hdr_valid),
        .tx_hdr_ready  (tx_hdr_ready),
        .tx_hdr        (tx_hdr)
    );

    // Payload of echoed frames only, written under control of echo_ctrl
    payload_fifo payload_fifo_inst (
        .clk          (clk),
        .rst          (rst),
        .fifo_wr      (fifo_wr),
        .wr_beat      (rx_pay),
        .fifo_free    (fifo_free),
        .tx_pay_valid (tx_pay_valid),
        .tx_pay_ready (tx_pay_ready),
        .tx_pay       (tx_pay)
    );

endmodule

`default_nettype wire

//--- tests/tb_udp_echo_core.sv
/*
 * Self-checking testbench for udp_echo_core.
 * Expected reply headers and beats are queued when frames are sent and
 * compared with every tx transfer. Inputs change 1 ns after the rising
 * edge, and tx transfers are sampled on the falling edge.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_udp_echo_core;

    logic                     clk;
    logic                     rst;
    logic                     rx_hdr_valid;
    logic                     rx_hdr_ready;
    udp_frame_pkg::udp_hdr_t  rx_hdr;
    logic                     rx_pay_valid;
    logic                     rx_pay_ready;
    udp_frame_pkg::pay_beat_t rx_pay;
    logic                     tx_hdr_valid;
    logic                     tx_hdr_ready;
    udp_frame_pkg::udp_hdr_t  tx_hdr;
    logic                     tx_pay_valid;
    logic                     tx_pay_ready;
    udp_frame_pkg::pay_beat_t tx_pay;

    // Reference model queues
    udp_frame_pkg::udp_hdr_t  exp_hdr_q[$];
    udp_frame_pkg::pay_beat_t exp_beat_q[$];
    udp_frame_pkg::udp_hdr_t  exp_hdr;
    udp_frame_pkg::pay_beat_t exp_beat;

    int    seed = 93;
    int    ready_seed;
    string test_name = "reset";
    int    mon_errors = 0;
    int    seq_errors = 0;
    int    errors_at_start = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    rx_hdrs = 0;
    int    rx_beats = 0;
    logic  hdr_hold = 1'b0;
    logic  pay_hold = 1'b0;
    logic  rand_ready = 1'b0;

    udp_echo_core udp_echo_core_inst (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_hdr       (rx_hdr),
        .rx_pay_valid (rx_pay_valid),
        .rx_pay_ready (rx_pay_ready),
        .rx_pay       (rx_pay),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_hdr       (tx_hdr),
        .tx_pay_valid (tx_pay_valid),
        .tx_pay_ready (tx_pay_ready),
        .tx_pay       (tx_pay)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // tx ready pattern, picked on the falling edge and applied after the rising one
    initial begin
        logic [31:0] r;
        logic        next_h;
        logic        next_p;
        ready_seed = seed;
        tx_hdr_ready = 1'b1;
        tx_pay_ready = 1'b1;
        forever begin
            @(negedge clk);
            r = $random(ready_seed);
            next_h = !hdr_hold && (!rand_ready || r[0]);
            next_p = !pay_hold && (!rand_ready || r[1]);
            @(posedge clk);
            #1;
            tx_hdr_ready = next_h;
            tx_pay_ready = next_p;
        end
    end

    // Compare every tx transfer with the head of its queue
    always @(negedge clk) begin
        if (rx_hdr_valid && rx_hdr_ready) begin
            rx_hdrs++;
        end
        if (rx_pay_valid && rx_pay_ready) begin
            rx_beats++;
        end
        if (tx_hdr_valid && tx_hdr_ready) begin
            assert (exp_hdr_q.size() != 0) else begin
                $display("ERROR %0s: a reply header was sent when none was expected", test_name);
                mon_errors++;
            end
            if (exp_hdr_q.size() != 0) begin
                exp_hdr = exp_hdr_q.pop_front();
                assert (tx_hdr == exp_hdr) else begin
                    $display("CHECK FAILED %0s: header expected %h actual %h",
                             test_name, exp_hdr, tx_hdr);
                    mon_errors++;
                end
            end
        end
        if (tx_pay_valid && tx_pay_ready) begin
            assert (exp_beat_q.size() != 0) else begin
                $display("ERROR %0s: a payload beat was sent when none was expected", test_name);
                mon_errors++;
            end
            if (exp_beat_q.size() != 0) begin
                exp_beat = exp_beat_q.pop_front();
                assert (tx_pay == exp_beat) else begin
                    $display("CHECK FAILED %0s: beat expected %h actual %h",
                             test_name, exp_beat, tx_pay);
                    mon_errors++;
                end
            end
        end
    end

    // Reply rules: from 192.168.1.128 back to sender, ports swapped, zero checksum, TTL 64
    function automatic udp_frame_pkg::udp_hdr_t expected_reply(input udp_frame_pkg::udp_hdr_t h);
        udp_frame_pkg::udp_hdr_t r;
        r.src_ip   = {8'd192, 8'd168, 8'd1, 8'd128};
        r.dst_ip   = h.src_ip;
        r.src_port = h.dst_port;
        r.dst_port = h.src_port;
        r.length   = h.length;
        r.checksum = 16'h0000;
        r.ttl      = 8'd64;
        return r;
    endfunction

    function automatic udp_frame_pkg::udp_hdr_t random_header(
        input udp_frame_pkg::udp_port_t port,
        input int                       nbeats
    );
        udp_frame_pkg::udp_hdr_t h;
        logic [31:0]             r;
        r = $random(seed);
        h.src_ip   = $random(seed);
        h.dst_ip   = $random(seed);
        h.src_port = r[15:0];
        h.dst_port = port;
        h.length   = 16'(8 + 8 * nbeats);
        h.checksum = r[31:16];
        h.ttl      = 8'd17;
        return h;
    endfunction

    function automatic int random_len();
        logic [31:0] r;
        r = $random(seed);
        return 1 + int'(r % 32'd20);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input udp_frame_pkg::udp_hdr_t hdr, input int nbeats);
        udp_frame_pkg::pay_beat_t beat;
        logic [31:0]              r;
        logic                     echo;
        logic                     taken;
        // Only port 1234 is answered
        echo = (hdr.dst_port == 16'd1234);
        if (echo) begin
            exp_hdr_q.push_back(expected_reply(hdr));
        end
        rx_hdr = hdr;
        rx_hdr_valid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = rx_hdr_ready;
            next_cycle();
        end
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < nbeats; i++) begin
            r = $random(seed);
            beat.data = {$random(seed), $random(seed)};
            beat.keep = r[7:0];
            beat.last = (i == nbeats - 1);
            beat.user = beat.last && r[8];
            if (echo) begin
                exp_beat_q.push_back(beat);
            end
            rx_pay = beat;
            rx_pay_valid = 1'b1;
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = rx_pay_ready;
                next_cycle();
            end
        end
        rx_pay_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            next_cycle();
        end
        // A few more cycles to catch stray replies
        repeat (8) next_cycle();
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = mon_errors + seq_errors;
    endtask

    task automatic finish_test();
        int n;
        n = mon_errors + seq_errors - errors_at_start;
        tests_run++;
        if (n != 0) begin
            tests_failed++;
        end
        $display("%0s: finished with %0d error(s)", test_name, n);
    endtask

    initial begin
        udp_frame_pkg::udp_port_t port;
        logic [31:0]              r;
        int                       len;
        int                       mark;
        rst = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_hdr = '0;
        rx_pay_valid = 1'b0;
        rx_pay = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test("reset_idle");
        repeat (10) begin
            @(negedge clk);
            assert (!tx_hdr_valid && !tx_pay_valid) else begin
                $display("CHECK FAILED %0s: tx valids expected 00 actual %b%b",
                         test_name, tx_hdr_valid, tx_pay_valid);
                seq_errors++;
            end
        end
        next_cycle();
        finish_test();

        start_test("single_echo");
        send_frame(random_header(echo_cfg_pkg::ECHO_PORT, 4), 4);
        wait_drain();
        finish_test();

        start_test("echo_lengths");
        for (int n = 1; n <= 20; n++) begin
            send_frame(random_header(echo_cfg_pkg::ECHO_PORT, n), n);
        end
        wait_drain();
        finish_test();

        start_test("mixed_ports");
        for (int n = 0; n < 8; n++) begin
            if (n % 3 == 1) begin
                port = echo_cfg_pkg::ECHO_PORT;
            end else begin
                port = (n % 3 == 0) ? 16'd53 : 16'd1235;
            end
            len = random_len();
            send_frame(random_header(port, len), len);
        end
        wait_drain();
        finish_test();

        start_test("backpressure");
        pay_hold = 1'b1;
        mark = rx_beats;
        fork
            send_frame(random_header(echo_cfg_pkg::ECHO_PORT, 20), 20);
            begin
                repeat (40) @(posedge clk);
                #2;
                assert (rx_beats - mark <= 16 && !rx_pay_ready) else begin
                    $display("CHECK FAILED %0s: beats taken expected <= 16 actual %0d, ready %b",
                             test_name, rx_beats - mark, rx_pay_ready);
                    seq_errors++;
                end
                pay_hold = 1'b0;
            end
        join
        wait_drain();
        hdr_hold = 1'b1;
        next_cycle();
        next_cycle();
        mark = rx_hdrs;
        fork
            begin
                send_frame(random_header(echo_cfg_pkg::ECHO_PORT, 1), 1);
                send_frame(random_header(echo_cfg_pkg::ECHO_PORT, 1), 1);
            end
            begin
                repeat (30) @(posedge clk);
                #2;
                assert (rx_hdrs - mark == 1) else begin
                    $display("CHECK FAILED %0s: headers taken expected 1 actual %0d",
                             test_name, rx_hdrs - mark);
                    seq_errors++;
                end
                hdr_hold = 1'b0;
            end
        join
        wait_drain();
        finish_test();

        start_test("random_ready");
        rand_ready = 1'b1;
        for (int n = 0; n < 30; n++) begin
            r = $random(seed);
            port = r[0] ? echo_cfg_pkg::ECHO_PORT : (r[31:16] | 16'h8000);
            len = random_len();
            send_frame(random_header(port, len), len);
        end
        rand_ready = 1'b0;
        wait_drain();
        finish_test();

        $display("Summary: %0d tests run, %0d failing, %0d errors",
                 tests_run, tests_failed, mon_errors + seq_errors);
        if (mon_errors + seq_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Budget of 40 cycles per beat over all tests
    initial begin : watchdog
        int budget;
        budget = (10 + 4 + 210 + 8 * 20 + 22 + 30 * 20) * 40;
        repeat (budget) @(posedge clk);
        $display("Timed out: the tests did not finish within %0d cycles", budget);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hw/udp_frame_pkg.sv
hw/echo_cfg_pkg.sv
hw/echo_ctrl.sv
hw/reply_header_reg.sv
hw/payload_fifo.sv
hw/udp_echo_core.sv
tests/tb_udp_echo_core.sv

//--- Makefile
# Verilator simulation of the UDP echo core

VERILATOR ?= verilator
TOP       ?= tb_udp_echo_core
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: sim clean

# Pass or fail follows from the pass message in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)
